// File: fpga_rt_checker.sv
/*
 * Protocol checker for the realtime register wrapper
 * Response hold rules on AXI4-Lite and entropy nibble pacing
 */
module fpga_rt_checker (
    input logic               core_clk,
    input logic               hwif_out,
    input logic               bvalid,
    input logic               bready,
    input fpga_rt_pkg::resp_t bresp,
    input logic               rvalid,
    input logic               rready,
    input fpga_rt_pkg::data_t rdata,
    input fpga_rt_pkg::resp_t rresp,
    input logic               itrng_valid,
    input fpga_rt_pkg::data_t itrng_divisor
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [32:0] gap;   // Cycles since the last nibble
    logic        seen;
    logic        fail_seen = 1'b0;   // Sticky, polled by the testbench

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            gap  <= '0;
            seen <= 1'b0;
        end else if (itrng_valid) begin
            gap  <= 33'd1;
            seen <= 1'b1;
        end else if (gap != '1) begin
            gap <= gap + 33'd1;   // Saturates on long idle
        end
    end

    bresp_hold: assert property (@(posedge core_clk) disable iff (!hwif_out)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else begin
            fail_seen = 1'b1;
            $error("Write response dropped or changed before bready");
        end

    rdata_hold: assert property (@(posedge core_clk) disable iff (!hwif_out)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else begin
            fail_seen = 1'b1;
            $error("Read response dropped or changed before rready");
        end

    nibble_pacing: assert property (@(posedge core_clk) disable iff (!hwif_out)
        itrng_valid && seen |-> gap >= {1'b0, itrng_divisor} + 33'd1)
        else begin
            fail_seen = 1'b1;
            $error("Entropy nibbles closer than divisor+1 cycles");
        end

endmodule

// Wrapper scope sees both the register block ports and the feeder outputs
bind fpga_rt_wrapper fpga_rt_checker checker_i (
    .core_clk, .hwif_out,
    .bvalid, .bready, .bresp,
    .rvalid, .rready, .rdata, .rresp,
    .itrng_valid, .itrng_divisor
);

// File: fpga_rt_pkg.sv
/*
 * Realtime register wrapper package
 * Bus widths, register offsets, response codes and FIFO sizing
 */
package fpga_rt_pkg;

    typedef logic [31:0] addr_t;      // AXI4-Lite byte address
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  resp_t;
    typedef logic [7:0]  log_char_t;
    typedef logic [3:0]  nibble_t;    // One entropy nibble to the core

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // Register map, word aligned
    localparam addr_t CTRL_OFS              = 32'h00;
    localparam addr_t STATUS_OFS            = 32'h04;
    localparam addr_t GENERIC_INPUT_OFS     = 32'h08;
    localparam addr_t GENERIC_OUTPUT_OFS    = 32'h0C;
    localparam addr_t ITRNG_DIVISOR_OFS     = 32'h10;
    localparam addr_t CYCLE_COUNT_OFS       = 32'h14;
    localparam addr_t LOG_FIFO_DATA_OFS     = 32'h18;  // Read pops
    localparam addr_t LOG_FIFO_STATUS_OFS   = 32'h1C;
    localparam addr_t ITRNG_FIFO_DATA_OFS   = 32'h20;  // Write pushes
    localparam addr_t ITRNG_STATUS_OFS      = 32'h24;

    // Log character FIFO
    localparam int LOG_FIFO_DEPTH = 16;
    localparam int LOG_PTR_W      = $clog2(LOG_FIFO_DEPTH);
    localparam int LOG_CNT_W      = $clog2(LOG_FIFO_DEPTH + 1);

    // Entropy word FIFO and unpacker
    localparam int ITRNG_FIFO_DEPTH = 8;
    localparam int ITRNG_PTR_W      = $clog2(ITRNG_FIFO_DEPTH);
    localparam int ITRNG_CNT_W      = $clog2(ITRNG_FIFO_DEPTH + 1);
    localparam int NIBBLES_PER_WORD = 8;
    localparam int NIBBLE_IDX_W     = $clog2(NIBBLES_PER_WORD);

endpackage

// File: fpga_rt_regs.sv
/*
 * Realtime AXI4-Lite register block
 * Control, status and generic wires for the core, the log and entropy
 * FIFO access registers and a free-running cycle counter
 */
module fpga_rt_regs (
    input  logic                     core_clk,
    input  logic                     hwif_out,
    // AXI4-Lite write channels
    input  logic                     awvalid,
    output logic                     awready,
    input  fpga_rt_pkg::addr_t       awaddr,
    input  logic                     wvalid,
    output logic                     wready,
    input  fpga_rt_pkg::data_t       wdata,
    input  fpga_rt_pkg::strb_t       wstrb,
    output logic                     bvalid,
    input  logic                     bready,
    output fpga_rt_pkg::resp_t       bresp,
    // AXI4-Lite read channels
    input  logic                     arvalid,
    output logic                     arready,
    input  fpga_rt_pkg::addr_t       araddr,
    output logic                     rvalid,
    input  logic                     rready,
    output fpga_rt_pkg::data_t       rdata,
    output fpga_rt_pkg::resp_t       rresp,
    // Core side
    output logic                     core_pwrgood,
    output logic                     core_rst_b,
    output fpga_rt_pkg::data_t       generic_input,
    input  logic [7:0]               core_status,
    input  fpga_rt_pkg::data_t       generic_output,
    // Log FIFO
    output logic                     log_pop,
    input  fpga_rt_pkg::log_char_t   log_head,
    input  logic                     log_empty,
    input  logic                     log_full,
    // Entropy feeder
    output logic                     itrng_push,
    output fpga_rt_pkg::data_t       itrng_word,
    output logic                     itrng_fifo_reset,
    output fpga_rt_pkg::data_t       itrng_divisor,
    input  logic                     itrng_empty,
    input  logic                     itrng_full
);

    logic               ready_en;   // Low only in the cycle right after reset
    logic               wr_accept;
    logic               rd_accept;
    fpga_rt_pkg::addr_t wr_addr;
    fpga_rt_pkg::addr_t rd_addr;
    fpga_rt_pkg::data_t rd_value;
    fpga_rt_pkg::data_t cycle_count;

    function automatic logic is_mapped(input fpga_rt_pkg::addr_t addr);
        case (addr)
            fpga_rt_pkg::CTRL_OFS,
            fpga_rt_pkg::STATUS_OFS,
            fpga_rt_pkg::GENERIC_INPUT_OFS,
            fpga_rt_pkg::GENERIC_OUTPUT_OFS,
            fpga_rt_pkg::ITRNG_DIVISOR_OFS,
            fpga_rt_pkg::CYCLE_COUNT_OFS,
            fpga_rt_pkg::LOG_FIFO_DATA_OFS,
            fpga_rt_pkg::LOG_FIFO_STATUS_OFS,
            fpga_rt_pkg::ITRNG_FIFO_DATA_OFS,
            fpga_rt_pkg::ITRNG_STATUS_OFS: is_mapped = 1'b1;
            default:                       is_mapped = 1'b0;
        endcase
    endfunction

    // Byte lane merge for RW registers
    function automatic fpga_rt_pkg::data_t merge_bytes(
        input fpga_rt_pkg::data_t old_val,
        input fpga_rt_pkg::data_t new_val,
        input fpga_rt_pkg::strb_t strb
    );
        fpga_rt_pkg::data_t merged;
        merged = old_val;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) merged[8*i +: 8] = new_val[8*i +: 8];
        end
        return merged;
    endfunction

    assign wr_addr = {awaddr[31:2], 2'b00};
    assign rd_addr = {araddr[31:2], 2'b00};

    // Address and data taken together, once no response is pending
    assign wr_accept = ready_en & awvalid & wvalid & ~bvalid;
    assign awready   = wr_accept;
    assign wready    = wr_accept;

    assign arready   = ready_en & ~rvalid;
    assign rd_accept = arvalid & arready;
    assign log_pop   = rd_accept && (rd_addr == fpga_rt_pkg::LOG_FIFO_DATA_OFS);

    always_comb begin
        case (rd_addr)
            fpga_rt_pkg::CTRL_OFS:            rd_value = {30'b0, core_rst_b, core_pwrgood};
            fpga_rt_pkg::STATUS_OFS:          rd_value = {24'b0, core_status};
            fpga_rt_pkg::GENERIC_INPUT_OFS:   rd_value = generic_input;
            fpga_rt_pkg::GENERIC_OUTPUT_OFS:  rd_value = generic_output;
            fpga_rt_pkg::ITRNG_DIVISOR_OFS:   rd_value = itrng_divisor;
            fpga_rt_pkg::CYCLE_COUNT_OFS:     rd_value = cycle_count;
            fpga_rt_pkg::LOG_FIFO_DATA_OFS:   rd_value = {23'b0, ~log_empty, log_head};
            fpga_rt_pkg::LOG_FIFO_STATUS_OFS: rd_value = {30'b0, log_full, log_empty};
            fpga_rt_pkg::ITRNG_STATUS_OFS:
                rd_value = {29'b0, itrng_fifo_reset, itrng_full, itrng_empty};
            default:                          rd_value = '0;  // Also the write-only data port
        endcase
    end

    // Response channels
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            ready_en <= 1'b0;
            bvalid   <= 1'b0;
            bresp    <= fpga_rt_pkg::RESP_OKAY;
            rvalid   <= 1'b0;
            rdata    <= '0;
            rresp    <= fpga_rt_pkg::RESP_OKAY;
        end else begin
            ready_en <= 1'b1;
            if (wr_accept) begin
                bvalid <= 1'b1;
                bresp  <= is_mapped(wr_addr) ? fpga_rt_pkg::RESP_OKAY : fpga_rt_pkg::RESP_SLVERR;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_accept) begin
                rvalid <= 1'b1;
                rdata  <= rd_value;   // Log head and valid sampled with the pop
                rresp  <= is_mapped(rd_addr) ? fpga_rt_pkg::RESP_OKAY : fpga_rt_pkg::RESP_SLVERR;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // RW registers and the entropy push strobe
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            core_pwrgood     <= 1'b0;
            core_rst_b       <= 1'b0;
            generic_input    <= '0;
            itrng_divisor    <= '0;
            itrng_fifo_reset <= 1'b0;
            itrng_push       <= 1'b0;
        end else begin
            itrng_push <= wr_accept && (wr_addr == fpga_rt_pkg::ITRNG_FIFO_DATA_OFS);
            if (wr_accept) begin
                case (wr_addr)
                    fpga_rt_pkg::CTRL_OFS: begin
                        if (wstrb[0]) begin
                            core_pwrgood <= wdata[0];
                            core_rst_b   <= wdata[1];
                        end
                    end
                    fpga_rt_pkg::GENERIC_INPUT_OFS:
                        generic_input <= merge_bytes(generic_input, wdata, wstrb);
                    fpga_rt_pkg::ITRNG_DIVISOR_OFS:
                        itrng_divisor <= merge_bytes(itrng_divisor, wdata, wstrb);
                    fpga_rt_pkg::ITRNG_STATUS_OFS: begin
                        if (wstrb[0]) itrng_fifo_reset <= wdata[2];  // Only bit2 is writable
                    end
                    default: ;
                endcase
            end
        end
    end

    // Word travels with the push pulse
    always_ff @(posedge core_clk) begin
        if (wr_accept && (wr_addr == fpga_rt_pkg::ITRNG_FIFO_DATA_OFS)) begin
            itrng_word <= wdata;
        end
    end

    // Cycle counter, held while the core is in reset
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            cycle_count <= '0;
        end else if (!core_rst_b) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

endmodule

// File: fpga_rt_wrapper.sv
/*
 * Realtime register wrapper top
 * Register block beside the log FIFO and the internal TRNG feeder
 */
module fpga_rt_wrapper (
    input  logic                   core_clk,
    input  logic                   hwif_out,
    // AXI4-Lite slave
    input  logic                   awvalid,
    output logic                   awready,
    input  fpga_rt_pkg::addr_t     awaddr,
    input  logic                   wvalid,
    output logic                   wready,
    input  fpga_rt_pkg::data_t     wdata,
    input  fpga_rt_pkg::strb_t     wstrb,
    output logic                   bvalid,
    input  logic                   bready,
    output fpga_rt_pkg::resp_t     bresp,
    input  logic                   arvalid,
    output logic                   arready,
    input  fpga_rt_pkg::addr_t     araddr,
    output logic                   rvalid,
    input  logic                   rready,
    output fpga_rt_pkg::data_t     rdata,
    output fpga_rt_pkg::resp_t     rresp,
    // Core side
    output logic                   core_pwrgood,
    output logic                   core_rst_b,
    output fpga_rt_pkg::data_t     generic_input,
    input  logic [7:0]             core_status,
    input  fpga_rt_pkg::data_t     generic_output,
    input  logic                   log_char_valid,
    input  fpga_rt_pkg::log_char_t log_char,
    input  logic                   etrng_req,
    output fpga_rt_pkg::nibble_t   itrng_data,
    output logic                   itrng_valid
);

    logic                   log_pop;
    fpga_rt_pkg::log_char_t log_head;
    logic                   log_empty;
    logic                   log_full;
    logic                   itrng_push;
    fpga_rt_pkg::data_t     itrng_word;
    logic                   itrng_fifo_reset;
    fpga_rt_pkg::data_t     itrng_divisor;
    logic                   itrng_empty;
    logic                   itrng_full;

    fpga_rt_regs regs_i (
        .core_clk, .hwif_out,
        .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
        .bvalid, .bready, .bresp,
        .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
        .core_pwrgood, .core_rst_b, .generic_input, .core_status, .generic_output,
        .log_pop, .log_head, .log_empty, .log_full,
        .itrng_push, .itrng_word, .itrng_fifo_reset, .itrng_divisor,
        .itrng_empty, .itrng_full
    );

    log_fifo log_fifo_i (
        .core_clk, .hwif_out,
        .log_char_valid, .log_char,
        .log_pop, .log_head, .log_empty, .log_full
    );

    itrng_feeder itrng_feeder_i (
        .core_clk, .hwif_out,
        .itrng_push, .itrng_word, .itrng_fifo_reset, .itrng_divisor,
        .etrng_req, .itrng_empty, .itrng_full,
        .itrng_data, .itrng_valid
    );

endmodule

// File: itrng_feeder.sv
/*
 * Internal TRNG feeder
 * Buffers host entropy words and hands them to the core one nibble at a
 * time, lowest first, paced by a divisor-throttled request
 */
module itrng_feeder (
    input  logic                 core_clk,
    input  logic                 hwif_out,
    input  logic                 itrng_push,
    input  fpga_rt_pkg::data_t   itrng_word,
    input  logic                 itrng_fifo_reset,
    input  fpga_rt_pkg::data_t   itrng_divisor,
    input  logic                 etrng_req,
    output logic                 itrng_empty,
    output logic                 itrng_full,
    output fpga_rt_pkg::nibble_t itrng_data,
    output logic                 itrng_valid
);

    fpga_rt_pkg::data_t                   mem [fpga_rt_pkg::ITRNG_FIFO_DEPTH];
    logic [fpga_rt_pkg::ITRNG_PTR_W-1:0]  wr_ptr;
    logic [fpga_rt_pkg::ITRNG_PTR_W-1:0]  rd_ptr;
    logic [fpga_rt_pkg::ITRNG_CNT_W-1:0]  count;
    logic [fpga_rt_pkg::NIBBLE_IDX_W-1:0] nib_idx;
    fpga_rt_pkg::data_t                   head_word;
    fpga_rt_pkg::data_t                   throttle_cnt;
    logic                                 req_strobe;
    logic                                 push_ok;
    logic                                 take;
    logic                                 word_done;

    localparam logic [fpga_rt_pkg::ITRNG_PTR_W-1:0] LAST_PTR =
        (fpga_rt_pkg::ITRNG_PTR_W)'(fpga_rt_pkg::ITRNG_FIFO_DEPTH - 1);
    localparam logic [fpga_rt_pkg::NIBBLE_IDX_W-1:0] LAST_NIB =
        (fpga_rt_pkg::NIBBLE_IDX_W)'(fpga_rt_pkg::NIBBLES_PER_WORD - 1);

    assign itrng_empty = (count == '0);
    assign itrng_full  = (count == (fpga_rt_pkg::ITRNG_CNT_W)'(fpga_rt_pkg::ITRNG_FIFO_DEPTH));
    assign head_word   = mem[rd_ptr];
    assign push_ok     = itrng_push & ~itrng_full & ~itrng_fifo_reset;
    assign take        = req_strobe & ~itrng_empty & ~itrng_fifo_reset;
    assign word_done   = take && (nib_idx == LAST_NIB);   // Last nibble frees the word

    // Throttle: one request sample every divisor+1 cycles
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            throttle_cnt <= '0;
            req_strobe   <= 1'b0;
        end else if (throttle_cnt == '0) begin
            throttle_cnt <= itrng_divisor;
            req_strobe   <= etrng_req;
        end else begin
            throttle_cnt <= throttle_cnt - 1'b1;
            req_strobe   <= 1'b0;
        end
    end

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            nib_idx     <= '0;
            itrng_valid <= 1'b0;
        end else if (itrng_fifo_reset) begin
            wr_ptr      <= '0;   // Host flush drops words and partial unpack
            rd_ptr      <= '0;
            count       <= '0;
            nib_idx     <= '0;
            itrng_valid <= 1'b0;
        end else begin
            itrng_valid <= take;
            if (take) begin
                nib_idx <= word_done ? '0 : nib_idx + 1'b1;
            end
            if (push_ok) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (word_done) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_ok, word_done})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge core_clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= itrng_word;
        end
        if (take) begin
            itrng_data <= head_word[{nib_idx, 2'b00} +: 4];
        end
    end

endmodule

// File: log_fifo.sv
/*
 * Core log character FIFO
 * First-word-fall-through buffer, drops characters while full
 */
module log_fifo (
    input  logic                   core_clk,
    input  logic                   hwif_out,
    input  logic                   log_char_valid,
    input  fpga_rt_pkg::log_char_t log_char,
    input  logic                   log_pop,
    output fpga_rt_pkg::log_char_t log_head,
    output logic                   log_empty,
    output logic                   log_full
);

    fpga_rt_pkg::log_char_t              mem [fpga_rt_pkg::LOG_FIFO_DEPTH];
    logic [fpga_rt_pkg::LOG_PTR_W-1:0]   wr_ptr;
    logic [fpga_rt_pkg::LOG_PTR_W-1:0]   rd_ptr;
    logic [fpga_rt_pkg::LOG_CNT_W-1:0]   count;
    logic                                push_ok;
    logic                                pop_ok;

    localparam logic [fpga_rt_pkg::LOG_PTR_W-1:0] LAST_IDX =
        (fpga_rt_pkg::LOG_PTR_W)'(fpga_rt_pkg::LOG_FIFO_DEPTH - 1);

    assign push_ok   = log_char_valid & ~log_full;
    assign pop_ok    = log_pop & ~log_empty;
    assign log_empty = (count == '0);
    assign log_full  = (count == (fpga_rt_pkg::LOG_CNT_W)'(fpga_rt_pkg::LOG_FIFO_DEPTH));
    assign log_head  = mem[rd_ptr];   // Head visible without a read strobe

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;   // Both or neither
            endcase
        end
    end

    always_ff @(posedge core_clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= log_char;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_fpga_rt -f sources.f -o tb_fpga_rt
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_fpga_rt > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Finished with no errors$" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

// File: sources.f
fpga_rt_pkg.sv
fpga_rt_regs.sv
log_fifo.sv
itrng_feeder.sv
fpga_rt_wrapper.sv
fpga_rt_checker.sv
tb_fpga_rt.sv

// File: tb_fpga_rt.sv
/*
 * Testbench for the realtime register wrapper
 * AXI4-Lite register access, log FIFO, entropy feeder and cycle counter
 */
module tb_fpga_rt;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 6000;   // Whole run needs well under 1000 cycles

    logic                   core_clk = 1'b0;
    logic                   hwif_out;
    logic                   awvalid, awready, wvalid, wready, bvalid, bready;
    logic                   arvalid, arready, rvalid, rready;
    fpga_rt_pkg::addr_t     awaddr, araddr;
    fpga_rt_pkg::data_t     wdata, rdata;
    fpga_rt_pkg::strb_t     wstrb;
    fpga_rt_pkg::resp_t     bresp, rresp;
    logic                   core_pwrgood, core_rst_b;
    fpga_rt_pkg::data_t     generic_input, generic_output;
    logic [7:0]             core_status;
    logic                   log_char_valid;
    fpga_rt_pkg::log_char_t log_char;
    logic                   etrng_req;
    fpga_rt_pkg::nibble_t   itrng_data;
    logic                   itrng_valid;
    int                     cycle_cnt = 0;

    fpga_rt_wrapper dut_i (.*);

    always #50 core_clk = ~core_clk;

    always @(posedge core_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $fatal(1);
        end
    end

    // Bound protocol checker failures end the run
    always @(negedge core_clk) begin
        if (dut_i.checker_i.fail_seen) begin
            $display("A protocol assertion in the bound checker failed");
            $display("Finished with errors");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input fpga_rt_pkg::data_t expected,
                               input fpga_rt_pkg::data_t actual);
        assert (actual == expected) else begin
            $display("CHECK FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    // Expected register value after a strobed write
    function automatic fpga_rt_pkg::data_t apply_strobes(input fpga_rt_pkg::data_t old_val,
                                                         input fpga_rt_pkg::data_t new_val,
                                                         input fpga_rt_pkg::strb_t strb);
        fpga_rt_pkg::data_t mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    task automatic axi_write(input fpga_rt_pkg::addr_t addr, input fpga_rt_pkg::data_t data,
                             input fpga_rt_pkg::strb_t strb, output fpga_rt_pkg::resp_t resp);
        @(negedge core_clk);
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        wstrb   = strb;
        do @(negedge core_clk); while (!bvalid);   // Response marks the accept
        awvalid = 1'b0;
        wvalid  = 1'b0;
        resp    = bresp;
    endtask

    task automatic axi_read(input fpga_rt_pkg::addr_t addr, input int stall,
                            output fpga_rt_pkg::data_t data, output fpga_rt_pkg::resp_t resp);
        @(negedge core_clk);
        check_value("arready_idle", 32'h1, 32'(arready));
        arvalid = 1'b1;
        araddr  = addr;
        rready  = (stall == 0);
        do @(negedge core_clk); while (!rvalid);
        check_value("arready_pending", 32'h0, 32'(arready));
        arvalid = 1'b0;
        data    = rdata;
        resp    = rresp;
        if (stall > 0) begin
            repeat (stall) @(negedge core_clk);
            rready = 1'b1;
        end
    endtask

    task automatic write_ok(input fpga_rt_pkg::addr_t addr, input fpga_rt_pkg::data_t data,
                            input fpga_rt_pkg::strb_t strb);
        fpga_rt_pkg::resp_t resp;
        axi_write(addr, data, strb, resp);
        check_value("write_resp", 32'(fpga_rt_pkg::RESP_OKAY), 32'(resp));
    endtask

    task automatic read_expect(input string name, input fpga_rt_pkg::addr_t addr,
                               input fpga_rt_pkg::data_t expected);
        fpga_rt_pkg::data_t data;
        fpga_rt_pkg::resp_t resp;
        axi_read(addr, 0, data, resp);
        check_value({name, "_resp"}, 32'(fpga_rt_pkg::RESP_OKAY), 32'(resp));
        check_value(name, expected, data);
    endtask

    task automatic push_log(input fpga_rt_pkg::log_char_t c);
        @(negedge core_clk);
        log_char_valid = 1'b1;
        log_char       = c;
        @(negedge core_clk);
        log_char_valid = 1'b0;
    endtask

    initial begin
        fpga_rt_pkg::data_t     words [3];
        fpga_rt_pkg::log_char_t log_q [$];
        fpga_rt_pkg::log_char_t c;
        fpga_rt_pkg::data_t     val, rd, c1, c2, ctrl_m, gin_m, div_m;
        fpga_rt_pkg::strb_t     strb;
        fpga_rt_pkg::resp_t     resp;
        int                     n;
        void'($urandom(74095));
        hwif_out       = 1'b0;
        awvalid        = 1'b0;
        awaddr         = '0;
        wvalid         = 1'b0;
        wdata          = '0;
        wstrb          = '0;
        bready         = 1'b1;
        arvalid        = 1'b0;
        araddr         = '0;
        rready         = 1'b1;
        core_status    = '0;
        generic_output = '0;
        log_char_valid = 1'b0;
        log_char       = '0;
        etrng_req      = 1'b0;
        repeat (16) @(negedge core_clk);
        hwif_out = 1'b1;

        // Entropy feeder, three words at divisor 3
        write_ok(fpga_rt_pkg::ITRNG_DIVISOR_OFS, 32'd3, 4'hF);
        for (int i = 0; i < 3; i++) begin
            words[i] = $urandom;
            write_ok(fpga_rt_pkg::ITRNG_FIFO_DATA_OFS, words[i], 4'hF);
        end
        etrng_req = 1'b1;
        n = 0;
        while (n < 24) begin
            @(negedge core_clk);
            if (itrng_valid) begin
                check_value("itrng_nibble", 32'(words[n / 8][4 * (n % 8) +: 4]),
                            32'(itrng_data));
                n++;
            end
        end
        etrng_req = 1'b0;
        read_expect("itrng_drained", fpga_rt_pkg::ITRNG_STATUS_OFS, 32'h1);
        write_ok(fpga_rt_pkg::ITRNG_FIFO_DATA_OFS, $urandom, 4'hF);
        read_expect("itrng_one_word", fpga_rt_pkg::ITRNG_STATUS_OFS, 32'h0);
        write_ok(fpga_rt_pkg::ITRNG_STATUS_OFS, 32'h4, 4'h1);
        read_expect("itrng_in_reset", fpga_rt_pkg::ITRNG_STATUS_OFS, 32'h5);
        write_ok(fpga_rt_pkg::ITRNG_STATUS_OFS, 32'h0, 4'h1);
        read_expect("itrng_flushed", fpga_rt_pkg::ITRNG_STATUS_OFS, 32'h1);

        // RW registers with random byte strobes
        ctrl_m = '0;
        gin_m  = '0;
        div_m  = 32'd3;
        for (int i = 0; i < 4; i++) begin
            val    = $urandom;
            strb   = 4'($urandom);
            ctrl_m = apply_strobes(ctrl_m, val, strb) & 32'h3;
            write_ok(fpga_rt_pkg::CTRL_OFS, val, strb);
            check_value("control_pins", ctrl_m, 32'({core_rst_b, core_pwrgood}));
            read_expect("control", fpga_rt_pkg::CTRL_OFS, ctrl_m);
            val   = $urandom;
            strb  = 4'($urandom);
            gin_m = apply_strobes(gin_m, val, strb);
            write_ok(fpga_rt_pkg::GENERIC_INPUT_OFS, val, strb);
            check_value("generic_input_pins", gin_m, generic_input);
            read_expect("generic_input", fpga_rt_pkg::GENERIC_INPUT_OFS, gin_m);
            val   = $urandom;
            strb  = 4'($urandom);
            div_m = apply_strobes(div_m, val, strb);
            write_ok(fpga_rt_pkg::ITRNG_DIVISOR_OFS, val, strb);
            read_expect("itrng_divisor", fpga_rt_pkg::ITRNG_DIVISOR_OFS, div_m);
        end
        core_status    = 8'($urandom);
        generic_output = $urandom;
        read_expect("status", fpga_rt_pkg::STATUS_OFS, 32'(core_status));
        read_expect("generic_output", fpga_rt_pkg::GENERIC_OUTPUT_OFS, generic_output);

        // Unmapped write held on bready, the next write waits for the response
        @(negedge core_clk);
        awvalid = 1'b1;
        awaddr  = 32'h40;
        wvalid  = 1'b1;
        wdata   = $urandom;
        wstrb   = 4'hF;
        bready  = 1'b0;
        do @(negedge core_clk); while (!bvalid);
        check_value("unmapped_write_resp", 32'(fpga_rt_pkg::RESP_SLVERR), 32'(bresp));
        gin_m  = $urandom;
        awaddr = fpga_rt_pkg::GENERIC_INPUT_OFS;
        wdata  = gin_m;
        repeat (5) begin
            @(negedge core_clk);
            check_value("write_stalled", 32'h4, 32'({bvalid, awready, wready}));
        end
        bready = 1'b1;
        @(negedge core_clk);
        check_value("write_ready", 32'h3, 32'({bvalid, awready, wready}));
        do @(negedge core_clk); while (!bvalid);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        check_value("write_after_stall_resp", 32'(fpga_rt_pkg::RESP_OKAY), 32'(bresp));

        // Unmapped read held on rready
        axi_read(32'h44, 5, rd, resp);
        check_value("unmapped_read_resp", 32'(fpga_rt_pkg::RESP_SLVERR), 32'(resp));
        check_value("unmapped_read_data", 32'h0, rd);
        read_expect("after_stall", fpga_rt_pkg::GENERIC_INPUT_OFS, gin_m);

        // Log FIFO order, empty read and overflow
        repeat (5) begin
            c = 8'($urandom);
            log_q.push_back(c);
            push_log(c);
        end
        while (log_q.size() > 0) begin
            read_expect("log_data", fpga_rt_pkg::LOG_FIFO_DATA_OFS,
                        {23'b0, 1'b1, log_q.pop_front()});
        end
        axi_read(fpga_rt_pkg::LOG_FIFO_DATA_OFS, 0, rd, resp);
        check_value("log_empty_valid", 32'h0, 32'(rd[8]));
        read_expect("log_status_empty", fpga_rt_pkg::LOG_FIFO_STATUS_OFS, 32'h1);
        for (int i = 0; i < 20; i++) begin
            c = 8'($urandom);
            if (i < fpga_rt_pkg::LOG_FIFO_DEPTH) log_q.push_back(c);
            push_log(c);
        end
        read_expect("log_status_full", fpga_rt_pkg::LOG_FIFO_STATUS_OFS, 32'h2);
        while (log_q.size() > 0) begin
            read_expect("log_overflow", fpga_rt_pkg::LOG_FIFO_DATA_OFS,
                        {23'b0, 1'b1, log_q.pop_front()});
        end
        read_expect("log_status_drained", fpga_rt_pkg::LOG_FIFO_STATUS_OFS, 32'h1);

        // Cycle counter held in core reset, then running
        write_ok(fpga_rt_pkg::CTRL_OFS, 32'h1, 4'h1);
        read_expect("cycle_count_held", fpga_rt_pkg::CYCLE_COUNT_OFS, 32'h0);
        write_ok(fpga_rt_pkg::CTRL_OFS, 32'h3, 4'h1);
        axi_read(fpga_rt_pkg::CYCLE_COUNT_OFS, 0, c1, resp);
        repeat (10) @(negedge core_clk);
        axi_read(fpga_rt_pkg::CYCLE_COUNT_OFS, 0, c2, resp);
        assert (c2 - c1 >= 32'd10) else begin
            $display("CHECK FAILED cycle_count_delta: expected at least 10, actual %0d", c2 - c1);
            $display("Finished with errors");
            $fatal(1);
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule
